/* soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ======================================================================
// Bus widths
// ======================================================================

`define SOC_DATA_W 32
`define SOC_ADDR_W 32

// ======================================================================
// Address map
// ======================================================================

// Region is the top nibble of the byte address
`define SOC_REGION_RAM 4'h1
`define SOC_REGION_SYS 4'h4

// RAM depth in 32-bit words, power of two
`define SOC_RAM_WORDS 1024

// ======================================================================
// System register block
// ======================================================================

// Word offsets, taken from address bits 3:2
`define SOC_REG_LED   2'd0
`define SOC_REG_TCTRL 2'd1
`define SOC_REG_TCMP  2'd2
`define SOC_REG_TCNT  2'd3

// Board LED count
`define SOC_LED_W 10

`endif

/* soc_pkg.sv */
`include "soc_defines.svh"

package soc_pkg;

	// Bus payload types
	typedef logic [`SOC_DATA_W-1:0] word_t;
	typedef logic [`SOC_ADDR_W-1:0] addr_t;

	// Address fields
	typedef logic [3:0] region_t;
	typedef logic [1:0] reg_off_t;

	typedef logic [`SOC_LED_W-1:0] led_t;

	// Shared bus owner
	typedef enum logic [1:0] {
		arb_idle,
		arb_grant_f,
		arb_grant_d
	} arb_state_t;

	// Top nibble selects the slave
	function automatic region_t region_of(input addr_t adr);
		return adr[`SOC_ADDR_W-1 -: 4];
	endfunction

	// Word offset inside the register block
	function automatic reg_off_t reg_off_of(input addr_t adr);
		return adr[3:2];
	endfunction

endpackage

/* wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter import soc_pkg::*; (
	input  logic  clock,
	input  logic  i_arst_n,

	// Fetch master, read only
	input  logic  i_f_cyc,
	input  logic  i_f_stb,
	input  addr_t i_f_adr,
	output word_t o_f_dat,
	output logic  o_f_ack,
	output logic  o_f_err,

	// Data master
	input  logic  i_d_cyc,
	input  logic  i_d_stb,
	input  logic  i_d_we,
	input  addr_t i_d_adr,
	input  word_t i_d_dat,
	output word_t o_d_dat,
	output logic  o_d_ack,
	output logic  o_d_err,

	// Shared bus towards the decoder
	output logic  o_bus_cyc,
	output logic  o_bus_stb,
	output logic  o_bus_we,
	output addr_t o_bus_adr,
	output word_t o_bus_dat,
	input  word_t i_bus_dat,
	input  logic  i_bus_ack,
	input  logic  i_bus_err
);

	arb_state_t state;
	arb_state_t state_nxt;

	// ==================================================================
	// Grant FSM
	// ==================================================================

	always_comb begin
		state_nxt = state;
		case (state)
			arb_idle: begin
				// Data master wins a tie
				if (i_d_cyc)
					state_nxt = arb_grant_d;
				else if (i_f_cyc)
					state_nxt = arb_grant_f;
			end
			arb_grant_f: if (!i_f_cyc) state_nxt = arb_idle;
			arb_grant_d: if (!i_d_cyc) state_nxt = arb_idle;
			default: state_nxt = arb_idle;
		endcase
	end

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n)
			state <= arb_idle;
		else
			state <= state_nxt;
	end

	// ==================================================================
	// Bus mux and response routing
	// ==================================================================

	assign o_bus_cyc = (state == arb_grant_d) ? i_d_cyc :
	                   (state == arb_grant_f) ? i_f_cyc : 1'b0;
	assign o_bus_stb = (state == arb_grant_d) ? i_d_stb :
	                   (state == arb_grant_f) ? i_f_stb : 1'b0;
	// Fetch port never writes
	assign o_bus_we  = (state == arb_grant_d) & i_d_we;
	assign o_bus_adr = (state == arb_grant_f) ? i_f_adr : i_d_adr;
	assign o_bus_dat = i_d_dat;

	// Read data is shared, handshake only reaches the owner
	assign o_f_dat = i_bus_dat;
	assign o_d_dat = i_bus_dat;
	assign o_f_ack = (state == arb_grant_f) & i_bus_ack;
	assign o_f_err = (state == arb_grant_f) & i_bus_err;
	assign o_d_ack = (state == arb_grant_d) & i_bus_ack;
	assign o_d_err = (state == arb_grant_d) & i_bus_err;

	// A response belongs to the master that strobed under the same grant
	a_resp_to_grant: assert property (@(posedge clock) disable iff (!i_arst_n)
		(i_bus_ack || i_bus_err) |->
			state != arb_idle && $stable(state) && $past(o_bus_cyc && o_bus_stb))
		else $error("bus response outside a granted request");

endmodule

/* wb_decoder.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module wb_decoder import soc_pkg::*; (
	input  logic  clock,
	input  logic  i_arst_n,

	// Shared bus from the arbiter
	input  logic  i_bus_cyc,
	input  logic  i_bus_stb,
	input  logic  i_bus_we,
	input  addr_t i_bus_adr,
	output word_t o_bus_dat,
	output logic  o_bus_ack,
	output logic  o_bus_err,

	// Slave strobes
	output logic  o_ram_stb,
	output logic  o_sys_stb,

	// Slave responses
	input  word_t i_ram_dat,
	input  word_t i_sys_dat,
	input  logic  i_ram_ack,
	input  logic  i_sys_ack
);

	region_t region;
	logic    req;
	logic    ram_sel;
	logic    sys_sel;

	assign region  = region_of(i_bus_adr);
	assign req     = i_bus_cyc & i_bus_stb;
	assign ram_sel = (region == `SOC_REGION_RAM);
	assign sys_sel = (region == `SOC_REGION_SYS);

	assign o_ram_stb = req & ram_sel;
	assign o_sys_stb = req & sys_sel;

	// Unmapped region, one err pulse per strobe
	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_bus_err <= 1'b0;
		else
			o_bus_err <= req & ~ram_sel & ~sys_sel & ~o_bus_err;
	end

	// Return path by region
	always_comb begin
		o_bus_dat = '0;
		o_bus_ack = 1'b0;
		case (region)
			`SOC_REGION_RAM: begin
				o_bus_dat = i_ram_dat;
				o_bus_ack = i_ram_ack;
			end
			`SOC_REGION_SYS: begin
				o_bus_dat = i_sys_dat;
				o_bus_ack = i_sys_ack;
			end
			default: ;
		endcase
	end

	// ==================================================================
	// Bus protocol checks
	// ==================================================================

	a_ack_err_excl: assert property (@(posedge clock) disable iff (!i_arst_n)
		!(o_bus_ack && o_bus_err))
		else $error("ack and err high together");

	// A waiting access keeps its address and direction
	a_req_stable: assert property (@(posedge clock) disable iff (!i_arst_n)
		(req && !o_bus_ack && !o_bus_err) |=>
			!i_bus_stb || ($stable(i_bus_adr) && $stable(i_bus_we)))
		else $error("bus request changed before its response");

endmodule

/* soc_ram.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_ram import soc_pkg::*; #(
	parameter int depth = `SOC_RAM_WORDS
) (
	input  logic  clock,
	input  logic  i_arst_n,

	input  logic  i_stb,
	input  logic  i_we,
	input  addr_t i_adr,
	input  word_t i_dat,
	output word_t o_dat,
	output logic  o_ack
);

	word_t                    mem [depth];
	logic [$clog2(depth)-1:0] idx;
	logic                     access;

	// Word index, upper bits wrap around the depth
	assign idx = i_adr[$clog2(depth)+1:2];

	// Only the first cycle of a strobe is served
	assign access = i_stb & ~o_ack;

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_ack <= 1'b0;
		else
			o_ack <= access;
	end

	// Array access on the acknowledging edge
	always_ff @(posedge clock) begin
		if (access) begin
			if (i_we)
				mem[idx] <= i_dat;
			o_dat <= mem[idx];
		end
	end

endmodule

/* sys_regs.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module sys_regs import soc_pkg::*; (
	input  logic  clock,
	input  logic  i_arst_n,

	// Slave port
	input  logic  i_stb,
	input  logic  i_we,
	input  addr_t i_adr,
	input  word_t i_dat,
	output word_t o_dat,
	output logic  o_ack,

	output led_t  o_led,

	// Timer counter control
	output logic  o_tmr_en,
	output logic  o_tmr_load,
	output word_t o_tmr_load_val,
	output word_t o_tmr_cmp,
	input  word_t i_tmr_count,
	input  logic  i_tmr_irq
);

	reg_off_t off;
	logic     access;
	logic     wr_en;
	word_t    rd_dat;

	assign off    = reg_off_of(i_adr);
	assign access = i_stb & ~o_ack;
	assign wr_en  = access & i_we;

	// ==================================================================
	// Register writes
	// ==================================================================

	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ack      <= 1'b0;
			o_led      <= '0;
			o_tmr_en   <= 1'b0;
			o_tmr_cmp  <= '0;
			o_tmr_load <= 1'b0;
		end else begin
			o_ack      <= access;
			// Counter write becomes a one-cycle load
			o_tmr_load <= wr_en && (off == `SOC_REG_TCNT);
			if (wr_en) begin
				case (off)
					`SOC_REG_LED:   o_led     <= i_dat[`SOC_LED_W-1:0];
					`SOC_REG_TCTRL: o_tmr_en  <= i_dat[0];
					`SOC_REG_TCMP:  o_tmr_cmp <= i_dat;
					default: ;
				endcase
			end
		end
	end

	// ==================================================================
	// Readback
	// ==================================================================

	always_comb begin
		case (off)
			`SOC_REG_LED:   rd_dat = {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, o_led};
			`SOC_REG_TCTRL: rd_dat = {{(`SOC_DATA_W-2){1'b0}}, i_tmr_irq, o_tmr_en};
			`SOC_REG_TCMP:  rd_dat = o_tmr_cmp;
			default:        rd_dat = i_tmr_count;
		endcase
	end

	always_ff @(posedge clock) begin
		if (wr_en && (off == `SOC_REG_TCNT))
			o_tmr_load_val <= i_dat;
		if (access)
			o_dat <= rd_dat;
	end

	a_ack_after_stb: assert property (@(posedge clock) disable iff (!i_arst_n)
		o_ack |-> $past(i_stb))
		else $error("register ack without a strobe");

endmodule

/* timer_counter.sv */
`timescale 1ns/1ps

module timer_counter import soc_pkg::*; (
	input  logic  clock,
	input  logic  i_arst_n,

	input  logic  i_en,
	input  logic  i_load,
	input  word_t i_load_val,
	input  word_t i_cmp,

	output word_t o_count,
	output logic  o_irq
);

	// Load wins over counting, count wraps at the top
	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_count <= '0;
		end else if (i_load) begin
			o_count <= i_load_val;
		end else if (i_en) begin
			o_count <= o_count + 1'b1;
		end
	end

	// Level interrupt, follows the compare every cycle
	always_ff @(posedge clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_irq <= 1'b0;
		else
			o_irq <= i_en & (o_count >= i_cmp);
	end

endmodule

/* soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
	input  logic  clock,
	input  logic  i_arst_n,

	// Instruction fetch master
	input  logic  i_f_cyc,
	input  logic  i_f_stb,
	input  addr_t i_f_adr,
	output word_t o_f_dat,
	output logic  o_f_ack,
	output logic  o_f_err,

	// Data master
	input  logic  i_d_cyc,
	input  logic  i_d_stb,
	input  logic  i_d_we,
	input  addr_t i_d_adr,
	input  word_t i_d_dat,
	output word_t o_d_dat,
	output logic  o_d_ack,
	output logic  o_d_err,

	output led_t  o_led,
	output logic  o_timer_irq
);

	// Shared bus
	logic  bus_cyc;
	logic  bus_stb;
	logic  bus_we;
	addr_t bus_adr;
	word_t bus_dat_w;
	word_t bus_dat_r;
	logic  bus_ack;
	logic  bus_err;

	// Slave side
	logic  ram_stb;
	word_t ram_dat;
	logic  ram_ack;
	logic  sys_stb;
	word_t sys_dat;
	logic  sys_ack;

	// Timer control
	logic  tmr_en;
	logic  tmr_load;
	word_t tmr_load_val;
	word_t tmr_cmp;
	word_t tmr_count;

	// ==================================================================
	// Bus fabric
	// ==================================================================

	wb_arbiter arbiter_i (
		.clock     (clock),
		.i_arst_n  (i_arst_n),
		.i_f_cyc   (i_f_cyc),
		.i_f_stb   (i_f_stb),
		.i_f_adr   (i_f_adr),
		.o_f_dat   (o_f_dat),
		.o_f_ack   (o_f_ack),
		.o_f_err   (o_f_err),
		.i_d_cyc   (i_d_cyc),
		.i_d_stb   (i_d_stb),
		.i_d_we    (i_d_we),
		.i_d_adr   (i_d_adr),
		.i_d_dat   (i_d_dat),
		.o_d_dat   (o_d_dat),
		.o_d_ack   (o_d_ack),
		.o_d_err   (o_d_err),
		.o_bus_cyc (bus_cyc),
		.o_bus_stb (bus_stb),
		.o_bus_we  (bus_we),
		.o_bus_adr (bus_adr),
		.o_bus_dat (bus_dat_w),
		.i_bus_dat (bus_dat_r),
		.i_bus_ack (bus_ack),
		.i_bus_err (bus_err)
	);

	wb_decoder decoder_i (
		.clock     (clock),
		.i_arst_n  (i_arst_n),
		.i_bus_cyc (bus_cyc),
		.i_bus_stb (bus_stb),
		.i_bus_we  (bus_we),
		.i_bus_adr (bus_adr),
		.o_bus_dat (bus_dat_r),
		.o_bus_ack (bus_ack),
		.o_bus_err (bus_err),
		.o_ram_stb (ram_stb),
		.o_sys_stb (sys_stb),
		.i_ram_dat (ram_dat),
		.i_sys_dat (sys_dat),
		.i_ram_ack (ram_ack),
		.i_sys_ack (sys_ack)
	);

	// ==================================================================
	// Slaves
	// ==================================================================

	soc_ram ram_i (
		.clock    (clock),
		.i_arst_n (i_arst_n),
		.i_stb    (ram_stb),
		.i_we     (bus_we),
		.i_adr    (bus_adr),
		.i_dat    (bus_dat_w),
		.o_dat    (ram_dat),
		.o_ack    (ram_ack)
	);

	sys_regs regs_i (
		.clock          (clock),
		.i_arst_n       (i_arst_n),
		.i_stb          (sys_stb),
		.i_we           (bus_we),
		.i_adr          (bus_adr),
		.i_dat          (bus_dat_w),
		.o_dat          (sys_dat),
		.o_ack          (sys_ack),
		.o_led          (o_led),
		.o_tmr_en       (tmr_en),
		.o_tmr_load     (tmr_load),
		.o_tmr_load_val (tmr_load_val),
		.o_tmr_cmp      (tmr_cmp),
		.i_tmr_count    (tmr_count),
		.i_tmr_irq      (o_timer_irq)
	);

	timer_counter timer_i (
		.clock      (clock),
		.i_arst_n   (i_arst_n),
		.i_en       (tmr_en),
		.i_load     (tmr_load),
		.i_load_val (tmr_load_val),
		.i_cmp      (tmr_cmp),
		.o_count    (tmr_count),
		.o_irq      (o_timer_irq)
	);

endmodule

/* tb_soc.sv */
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc import soc_pkg::*; ();

	localparam int access_timeout = 50;
	localparam int irq_timeout    = 200;

	logic  clock;
	logic  i_arst_n;
	logic  i_f_cyc;
	logic  i_f_stb;
	addr_t i_f_adr;
	word_t o_f_dat;
	logic  o_f_ack;
	logic  o_f_err;
	logic  i_d_cyc;
	logic  i_d_stb;
	logic  i_d_we;
	addr_t i_d_adr;
	word_t i_d_dat;
	word_t o_d_dat;
	logic  o_d_ack;
	logic  o_d_err;
	led_t  o_led;
	logic  o_timer_irq;

	// Expected RAM contents, keyed by word index
	word_t  ram_model [int];
	integer seed;

	soc_top dut_i (
		.clock       (clock),
		.i_arst_n    (i_arst_n),
		.i_f_cyc     (i_f_cyc),
		.i_f_stb     (i_f_stb),
		.i_f_adr     (i_f_adr),
		.o_f_dat     (o_f_dat),
		.o_f_ack     (o_f_ack),
		.o_f_err     (o_f_err),
		.i_d_cyc     (i_d_cyc),
		.i_d_stb     (i_d_stb),
		.i_d_we      (i_d_we),
		.i_d_adr     (i_d_adr),
		.i_d_dat     (i_d_dat),
		.o_d_dat     (o_d_dat),
		.o_d_ack     (o_d_ack),
		.o_d_err     (o_d_err),
		.o_led       (o_led),
		.o_timer_irq (o_timer_irq)
	);

	always #2 clock = ~clock;

	// ==================================================================
	// Failure reporting
	// ==================================================================

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic mismatch(input string name, input word_t got, input word_t exp);
		fail_now($sformatf("error at time %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// ==================================================================
	// RAM reference, word address modulo the depth
	// ==================================================================

	function automatic int word_index(input addr_t adr);
		return int'((adr >> 2) % `SOC_RAM_WORDS);
	endfunction

	function automatic logic is_ram(input addr_t adr);
		return adr[31:28] == `SOC_REGION_RAM;
	endfunction

	task automatic model_lookup(input addr_t adr, output word_t exp);
		assert (ram_model.exists(word_index(adr)))
			else fail_now("pattern reads a RAM word that was never written");
		exp = ram_model[word_index(adr)];
	endtask

	// ==================================================================
	// Bus tasks
	// ==================================================================

	task automatic bus_access(input logic use_fetch, input logic we, input addr_t adr,
		input word_t wdat, input logic exp_err, output word_t rdat);
		int   cycles;
		logic got_ack;
		logic got_err;
		logic other;
		@(posedge clock);
		#1;
		if (use_fetch) begin
			i_f_cyc = 1'b1;
			i_f_stb = 1'b1;
			i_f_adr = adr;
		end else begin
			i_d_cyc = 1'b1;
			i_d_stb = 1'b1;
			i_d_we  = we;
			i_d_adr = adr;
			i_d_dat = wdat;
		end
		cycles  = 0;
		got_ack = 1'b0;
		got_err = 1'b0;
		while (!got_ack && !got_err) begin
			@(posedge clock);
			#1;
			cycles++;
			assert (cycles <= access_timeout) else fail_now("timeout waiting for a bus response");
			got_ack = use_fetch ? o_f_ack : o_d_ack;
			got_err = use_fetch ? o_f_err : o_d_err;
			other   = use_fetch ? (o_d_ack | o_d_err) : (o_f_ack | o_f_err);
			assert (!other) else fail_now("response on the port that made no request");
		end
		assert (!(got_ack && got_err)) else fail_now("ack and err seen in the same cycle");
		assert (got_err == exp_err)
			else mismatch(use_fetch ? "o_f_err" : "o_d_err", 32'(got_err), 32'(exp_err));
		rdat = use_fetch ? o_f_dat : o_d_dat;
		// Request ends in the cycle after the response
		i_f_cyc = 1'b0;
		i_f_stb = 1'b0;
		i_d_cyc = 1'b0;
		i_d_stb = 1'b0;
		i_d_we  = 1'b0;
	endtask

	// Both masters read in the same cycle, acks may come in either order
	task automatic contend(input addr_t f_adr, input addr_t d_adr);
		int    cycles;
		int    f_acks;
		int    d_acks;
		word_t f_exp;
		word_t d_exp;
		model_lookup(f_adr, f_exp);
		model_lookup(d_adr, d_exp);
		@(posedge clock);
		#1;
		i_f_cyc = 1'b1;
		i_f_stb = 1'b1;
		i_f_adr = f_adr;
		i_d_cyc = 1'b1;
		i_d_stb = 1'b1;
		i_d_we  = 1'b0;
		i_d_adr = d_adr;
		cycles  = 0;
		f_acks  = 0;
		d_acks  = 0;
		while (f_acks == 0 || d_acks == 0) begin
			@(posedge clock);
			#1;
			cycles++;
			assert (cycles <= access_timeout) else fail_now("timeout during contention");
			assert (!o_f_err && !o_d_err) else fail_now("error response during contention");
			if (o_f_ack) begin
				assert (f_acks == 0) else fail_now("second ack on the fetch port");
				assert (o_f_dat == f_exp) else mismatch("o_f_dat", o_f_dat, f_exp);
				f_acks++;
				i_f_cyc = 1'b0;
				i_f_stb = 1'b0;
			end
			if (o_d_ack) begin
				assert (d_acks == 0) else fail_now("second ack on the data port");
				assert (o_d_dat == d_exp) else mismatch("o_d_dat", o_d_dat, d_exp);
				d_acks++;
				i_d_cyc = 1'b0;
				i_d_stb = 1'b0;
			end
		end
		// No stray acks afterwards
		repeat (3) begin
			@(posedge clock);
			#1;
			assert (!o_f_ack && !o_d_ack) else fail_now("extra ack after contention");
		end
	endtask

	task automatic wait_irq(input logic level);
		int cycles;
		cycles = 0;
		while (o_timer_irq !== level) begin
			@(posedge clock);
			#1;
			cycles++;
			assert (cycles <= irq_timeout) else fail_now("timeout waiting for the timer interrupt");
		end
	endtask

	// ==================================================================
	// Pattern driven sequence
	// ==================================================================

	initial begin
		int    fd;
		int    n;
		string line;
		string port;
		string op;
		string resp;
		addr_t adr;
		word_t dat;
		word_t rdat;
		word_t exp;
		logic  use_fetch;
		logic  exp_err;
		clock    = 1'b0;
		i_arst_n = 1'b0;
		i_f_cyc  = 1'b0;
		i_f_stb  = 1'b0;
		i_f_adr  = '0;
		i_d_cyc  = 1'b0;
		i_d_stb  = 1'b0;
		i_d_we   = 1'b0;
		i_d_adr  = '0;
		i_d_dat  = '0;
		seed     = 32'hd0ce_f967;
		repeat (10) @(posedge clock);
		#1;
		i_arst_n = 1'b1;

		fd = $fopen("soc_patterns.txt", "r");
		assert (fd != 0) else fail_now("cannot open soc_patterns.txt");
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 3 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %s %h %h %s", port, op, adr, dat, resp);
			assert (n == 5) else fail_now("malformed line in the pattern file");
			use_fetch = (port == "f");
			exp_err   = (resp == "err");
			if (op == "wr") begin
				bus_access(use_fetch, 1'b1, adr, dat, exp_err, rdat);
				// Fetch port has no write enable, so RAM keeps its word
				if (!exp_err && is_ram(adr) && !use_fetch)
					ram_model[word_index(adr)] = dat;
			end else if (op == "rnd") begin
				dat = $random(seed);
				bus_access(1'b0, 1'b1, adr, dat, exp_err, rdat);
				ram_model[word_index(adr)] = dat;
			end else if (op == "rd") begin
				bus_access(use_fetch, 1'b0, adr, '0, exp_err, rdat);
				if (!exp_err)
					assert (rdat == dat)
						else mismatch(use_fetch ? "o_f_dat" : "o_d_dat", rdat, dat);
			end else if (op == "chk" && port == "x") begin
				contend(adr, dat);
			end else if (op == "chk") begin
				model_lookup(adr, exp);
				bus_access(use_fetch, 1'b0, adr, '0, 1'b0, rdat);
				assert (rdat == exp)
					else mismatch(use_fetch ? "o_f_dat" : "o_d_dat", rdat, exp);
			end else if (op == "led") begin
				assert (o_led == dat[`SOC_LED_W-1:0])
					else mismatch("o_led", 32'(o_led), 32'(dat[`SOC_LED_W-1:0]));
			end else if (op == "irq") begin
				wait_irq(dat[0]);
			end else if (op == "ilo") begin
				// Low two cycles after the control write was acknowledged
				repeat (2) begin
					@(posedge clock);
					#1;
				end
				assert (o_timer_irq == 1'b0)
					else mismatch("o_timer_irq", 32'(o_timer_irq), 32'd0);
			end else begin
				fail_now("unknown operation in the pattern file");
			end
		end
		$fclose(fd);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* soc_patterns.txt */
# port op addr data resp : port d=data f=fetch x=both, '-' for non-bus checks
# chk compares with written RAM words; x chk takes the fetch address, then the data address
d wr 10000000 a5a5a5a5 ack
d wr 10000004 5a5a5a5a ack
d rd 10000000 a5a5a5a5 ack
d rd 10000004 5a5a5a5a ack
d rnd 10000100 0 ack
d chk 10000100 0 ack
d chk 10001100 0 ack
d rnd 10000ffc 0 ack
d chk 10002ffc 0 ack
f rd 10000000 a5a5a5a5 ack
f chk 10000100 0 ack
d rd 00000000 0 err
f rd 30000010 0 err
d wr a0000000 deadbeef err
d wr 40000000 ffffffff ack
- led 0 3ff -
d rd 40000000 000003ff ack
d wr 4000000c 0 ack
d wr 40000008 32 ack
d wr 40000004 1 ack
- irq 0 1 -
d rd 40000004 3 ack
d wr 40000004 0 ack
- ilo 0 0 -
d rd 40000004 0 ack
x chk 10000004 10000000 ack

/* src.f */
+incdir+.
soc_pkg.sv
wb_arbiter.sv
wb_decoder.sv
soc_ram.sv
sys_regs.sv
timer_counter.sv
soc_top.sv
tb_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f src.f -o sim_tb_soc

# The log decides pass or fail, even when the simulator stops early
./obj_dir/sim_tb_soc | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
